// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

	// rv32i only
	localparam int XLEN = 32;
	localparam int NUM_REGS = 32;

	// data, address and immediate words
	typedef logic [XLEN-1:0] word_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;
	typedef logic [6:0] opcode_t;
	// alu function follows the funct3 encoding
	typedef logic [2:0] alu_op_t;
	typedef logic [1:0] op1_sel_t;
	typedef logic [1:0] wb_sel_t;

	// base opcodes, instruction bits 6:0
	localparam opcode_t OP_LUI = 7'b0110111;
	localparam opcode_t OP_AUIPC = 7'b0010111;
	localparam opcode_t OP_JAL = 7'b1101111;
	localparam opcode_t OP_JALR = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD = 7'b0000011;
	localparam opcode_t OP_STORE = 7'b0100011;
	localparam opcode_t OP_ALU_IMM = 7'b0010011;
	localparam opcode_t OP_ALU_REG = 7'b0110011;

	localparam alu_op_t ALU_ADD = 3'b000;
	localparam alu_op_t ALU_SLL = 3'b001;
	localparam alu_op_t ALU_SLT = 3'b010;
	localparam alu_op_t ALU_SLTU = 3'b011;
	localparam alu_op_t ALU_XOR = 3'b100;
	localparam alu_op_t ALU_SRL = 3'b101;
	localparam alu_op_t ALU_OR = 3'b110;
	localparam alu_op_t ALU_AND = 3'b111;

	// alu operand 1 source
	localparam op1_sel_t OP1_RS1 = 2'd0;
	localparam op1_sel_t OP1_PC = 2'd1;
	localparam op1_sel_t OP1_ZERO = 2'd2;

	// register file writeback source
	localparam wb_sel_t WB_ALU = 2'd0;
	localparam wb_sel_t WB_MEM = 2'd1;
	localparam wb_sel_t WB_PC4 = 2'd2;

	// everything the datapath needs from one instruction
	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		alu_op_t alu_op;
		logic alt;
		op1_sel_t op1_src;
		logic op2_imm;
		wb_sel_t wb_sel;
		logic branch;
		logic branch_if_zero;
		logic jump;
		logic jump_reg;
		logic rf_we;
		logic mem_we;
	} ctrl_t;

endpackage

`default_nettype wire

// ==== src/immediate_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module immediate_decode (
	input rv_pkg::word_t instruction,
	output rv_pkg::word_t immediate
);

	rv_pkg::opcode_t opcode;

	assign opcode = instruction[6:0];

	// bit 31 is the sign bit in every format
	always_comb
	begin
		case (opcode)
			// I type: loads, jalr and alu immediates
			rv_pkg::OP_ALU_IMM, rv_pkg::OP_LOAD, rv_pkg::OP_JALR:
				immediate = {{20{instruction[31]}}, instruction[31:20]};
			// S type splits the offset around rd
			rv_pkg::OP_STORE:
				immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
			// B type, offset in halfwords
			rv_pkg::OP_BRANCH:
				immediate = {
					{19{instruction[31]}},
					instruction[31],
					instruction[7],
					instruction[30:25],
					instruction[11:8],
					1'b0
				};
			// J type, 21 bit offset
			rv_pkg::OP_JAL:
				immediate = {
					{11{instruction[31]}},
					instruction[31],
					instruction[19:12],
					instruction[20],
					instruction[30:21],
					1'b0
				};
			// U type fills the upper 20 bits
			rv_pkg::OP_LUI, rv_pkg::OP_AUIPC:
				immediate = {instruction[31:12], 12'b0};
			default:
				immediate = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/alu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
	input rv_pkg::word_t instruction,
	output rv_pkg::alu_op_t alu_op,
	output logic alt,
	output rv_pkg::op1_sel_t op1_src,
	output logic op2_imm
);

	rv_pkg::opcode_t opcode;
	logic [2:0] funct3;

	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];

	// alu function and alternate bit
	always_comb
	begin
		alu_op = rv_pkg::ALU_ADD;
		alt = 1'b0;
		case (opcode)
			rv_pkg::OP_BRANCH:
			begin
				// compare through the alu, the zero flag decides
				case (funct3[2:1])
					// beq and bne subtract
					2'b00:
					begin
						alu_op = rv_pkg::ALU_ADD;
						alt = 1'b1;
					end
					// blt and bge
					2'b10:
						alu_op = rv_pkg::ALU_SLT;
					// bltu and bgeu
					2'b11:
						alu_op = rv_pkg::ALU_SLTU;
					default:
						alu_op = rv_pkg::ALU_ADD;
				endcase
			end
			rv_pkg::OP_ALU_REG:
			begin
				alu_op = funct3;
				// sub and sra
				alt = instruction[30];
			end
			rv_pkg::OP_ALU_IMM:
			begin
				alu_op = funct3;
				// only srai uses bit 30, addi keeps adding
				alt = (funct3 == rv_pkg::ALU_SRL) ? instruction[30] : 1'b0;
			end
			// lui, auipc, loads, stores and jumps just add
			default:
				alu_op = rv_pkg::ALU_ADD;
		endcase
	end

	// operand 1
	// lui adds the immediate to zero
	// auipc adds it to the pc
	always_comb
	begin
		case (opcode)
			rv_pkg::OP_LUI:
				op1_src = rv_pkg::OP1_ZERO;
			rv_pkg::OP_AUIPC:
				op1_src = rv_pkg::OP1_PC;
			default:
				op1_src = rv_pkg::OP1_RS1;
		endcase
	end

	// operand 2 is rs2 only where two registers are compared or combined
	assign op2_imm = !(opcode == rv_pkg::OP_ALU_REG || opcode == rv_pkg::OP_BRANCH);

endmodule

`default_nettype wire

// ==== src/instruction_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
	input rv_pkg::word_t instruction,
	output rv_pkg::ctrl_t ctrl,
	output rv_pkg::word_t immediate
);

	rv_pkg::opcode_t opcode;
	logic [2:0] funct3;

	// alu_decode results
	rv_pkg::alu_op_t alu_op;
	logic alt;
	rv_pkg::op1_sel_t op1_src;
	logic op2_imm;

	// branch and writeback decode
	logic branch_if_zero;
	rv_pkg::wb_sel_t wb_sel;
	logic rf_we;

	assign opcode = instruction[6:0];
	assign funct3 = instruction[14:12];

	immediate_decode u_immediate_decode (
		.instruction(instruction),
		.immediate(immediate)
	);

	alu_decode u_alu_decode (
		.instruction(instruction),
		.alu_op(alu_op),
		.alt(alt),
		.op1_src(op1_src),
		.op2_imm(op2_imm)
	);

	// taken when the zero flag equals this bit
	// beq: difference is zero
	// bge, bgeu: slt result is zero
	always_comb
	begin
		case (funct3)
			3'b000, 3'b101, 3'b111:
				branch_if_zero = 1'b1;
			default:
				branch_if_zero = 1'b0;
		endcase
	end

	// writeback source and register write enable
	// unknown opcodes write nothing
	always_comb
	begin
		wb_sel = rv_pkg::WB_ALU;
		rf_we = 1'b0;
		case (opcode)
			rv_pkg::OP_LUI, rv_pkg::OP_AUIPC, rv_pkg::OP_ALU_IMM, rv_pkg::OP_ALU_REG:
				rf_we = 1'b1;
			rv_pkg::OP_LOAD:
			begin
				wb_sel = rv_pkg::WB_MEM;
				rf_we = 1'b1;
			end
			// link address
			rv_pkg::OP_JAL, rv_pkg::OP_JALR:
			begin
				wb_sel = rv_pkg::WB_PC4;
				rf_we = 1'b1;
			end
			default:
				rf_we = 1'b0;
		endcase
	end

	always_comb
	begin
		// register indices sit at fixed positions even when unused
		ctrl.rs1 = instruction[19:15];
		ctrl.rs2 = instruction[24:20];
		ctrl.rd = instruction[11:7];
		ctrl.alu_op = alu_op;
		ctrl.alt = alt;
		ctrl.op1_src = op1_src;
		ctrl.op2_imm = op2_imm;
		ctrl.wb_sel = wb_sel;
		ctrl.branch = (opcode == rv_pkg::OP_BRANCH);
		ctrl.branch_if_zero = branch_if_zero;
		ctrl.jump = (opcode == rv_pkg::OP_JAL) || (opcode == rv_pkg::OP_JALR);
		// jalr takes its base from rs1 instead of pc
		ctrl.jump_reg = (opcode == rv_pkg::OP_JALR);
		ctrl.rf_we = rf_we;
		ctrl.mem_we = (opcode == rv_pkg::OP_STORE);
	end

endmodule

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input logic clk,
	input logic reset,
	input rv_pkg::reg_idx_t rs1,
	input rv_pkg::reg_idx_t rs2,
	input rv_pkg::reg_idx_t rd,
	input logic we,
	input rv_pkg::word_t wdata,
	output rv_pkg::word_t rdata1,
	output rv_pkg::word_t rdata2
);

	// x0 has no storage
	rv_pkg::word_t regs [1:rv_pkg::NUM_REGS-1];

	// one write per cycle, x0 writes dropped
	always_ff @(posedge clk)
	begin
		if (!reset && we && rd != '0)
		begin
			regs[rd] <= wdata;
		end
	end

	// combinational reads
	// a write lands at the edge, so the same cycle sees the old value
	assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input rv_pkg::alu_op_t op,
	input logic alt,
	input rv_pkg::word_t a,
	input rv_pkg::word_t b,
	output rv_pkg::word_t result,
	output logic zero
);

	logic [4:0] shamt;
	logic lt_signed;
	logic lt_unsigned;

	// only the low five bits shift
	assign shamt = b[4:0];
	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb
	begin
		case (op)
			// alt selects subtract
			rv_pkg::ALU_ADD:
				result = alt ? (a - b) : (a + b);
			rv_pkg::ALU_SLL:
				result = a << shamt;
			rv_pkg::ALU_SLT:
				result = {{(rv_pkg::XLEN-1){1'b0}}, lt_signed};
			rv_pkg::ALU_SLTU:
				result = {{(rv_pkg::XLEN-1){1'b0}}, lt_unsigned};
			rv_pkg::ALU_XOR:
				result = a ^ b;
			// alt selects arithmetic shift
			rv_pkg::ALU_SRL:
				result = alt ? rv_pkg::word_t'($signed(a) >>> shamt) : (a >> shamt);
			rv_pkg::ALU_OR:
				result = a | b;
			rv_pkg::ALU_AND:
				result = a & b;
			default:
				result = '0;
		endcase
	end

	// branch compare flag
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== src/rv32i_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32i_core (
	input logic clk,
	input logic reset,
	output rv_pkg::word_t imem_addr,
	input rv_pkg::word_t imem_data,
	output rv_pkg::word_t dmem_addr,
	output rv_pkg::word_t dmem_wdata,
	output logic dmem_we,
	input rv_pkg::word_t dmem_rdata
);

	rv_pkg::word_t pc;
	rv_pkg::word_t pc_plus4;
	rv_pkg::word_t next_pc;

	rv_pkg::ctrl_t ctrl;
	rv_pkg::word_t immediate;

	// register file read data and writeback
	rv_pkg::word_t rs1_data;
	rv_pkg::word_t rs2_data;
	rv_pkg::word_t wb_data;

	// alu operands and outputs
	rv_pkg::word_t op1;
	rv_pkg::word_t op2;
	rv_pkg::word_t alu_result;
	logic alu_zero;

	// branch resolution
	logic taken;
	rv_pkg::word_t pc_target;
	rv_pkg::word_t jalr_sum;
	rv_pkg::word_t jalr_target;

	// fetch straight from the pc
	assign imem_addr = pc;

	instruction_decode u_instruction_decode (
		.instruction(imem_data),
		.ctrl(ctrl),
		.immediate(immediate)
	);

	register_file u_register_file (
		.clk(clk),
		.reset(reset),
		.rs1(ctrl.rs1),
		.rs2(ctrl.rs2),
		.rd(ctrl.rd),
		.we(ctrl.rf_we),
		.wdata(wb_data),
		.rdata1(rs1_data),
		.rdata2(rs2_data)
	);

	// operand 1: rs1, pc for auipc, zero for lui
	always_comb
	begin
		case (ctrl.op1_src)
			rv_pkg::OP1_RS1:
				op1 = rs1_data;
			rv_pkg::OP1_PC:
				op1 = pc;
			default:
				op1 = '0;
		endcase
	end

	assign op2 = ctrl.op2_imm ? immediate : rs2_data;

	alu u_alu (
		.op(ctrl.alu_op),
		.alt(ctrl.alt),
		.a(op1),
		.b(op2),
		.result(alu_result),
		.zero(alu_zero)
	);

	// data port
	// address from the alu add, store data always from rs2
	assign dmem_addr = alu_result;
	assign dmem_wdata = rs2_data;
	// no stores while in reset
	assign dmem_we = ctrl.mem_we && !reset;

	assign pc_plus4 = pc + 32'd4;

	always_comb
	begin
		case (ctrl.wb_sel)
			rv_pkg::WB_MEM:
				wb_data = dmem_rdata;
			rv_pkg::WB_PC4:
				wb_data = pc_plus4;
			default:
				wb_data = alu_result;
		endcase
	end

	// jumps always taken
	// branches when the zero flag matches the wanted value
	assign taken = ctrl.jump || (ctrl.branch && (ctrl.branch_if_zero == alu_zero));

	// pc relative target for branches and jal
	assign pc_target = pc + immediate;
	// jalr has its own adder, the alu is busy with nothing else but keep paths apart
	assign jalr_sum = rs1_data + immediate;
	// bit 0 cleared per spec
	assign jalr_target = {jalr_sum[rv_pkg::XLEN-1:1], 1'b0};

	always_comb
	begin
		if (!taken)
		begin
			next_pc = pc_plus4;
		end
		else if (ctrl.jump_reg)
		begin
			next_pc = jalr_target;
		end
		else
		begin
			next_pc = pc_target;
		end
	end

	// one instruction per clock
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= '0;
		end
		else
		begin
			pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_rv32i_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_core;

	localparam int NUM_INSTR = 2000;
	localparam int RESET_CYCLES = 3;
	localparam int CLK_PERIOD = 40;
	// store of x0 to address 0 held on the fetch port during reset
	localparam rv_pkg::word_t RESET_STORE = 32'h00002023;

	logic clk;
	logic reset;
	rv_pkg::word_t imem_addr;
	rv_pkg::word_t imem_data;
	rv_pkg::word_t dmem_addr;
	rv_pkg::word_t dmem_wdata;
	rv_pkg::word_t dmem_rdata;
	logic dmem_we;

	// memories filled on first touch
	rv_pkg::word_t imem [rv_pkg::word_t];
	rv_pkg::word_t dmem [rv_pkg::word_t];

	// reference model state
	rv_pkg::word_t m_regs [rv_pkg::NUM_REGS];
	rv_pkg::word_t m_pc;

	logic [31:0] lfsr;
	int fill_count;
	int errors;
	int checks;

	rv32i_core u_dut (
		.clk(clk),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_we(dmem_we),
		.dmem_rdata(dmem_rdata)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	// reset cycles plus every instruction plus ten cycles of slack
	initial
	begin
		#((NUM_INSTR + RESET_CYCLES + 10) * CLK_PERIOD);
		$display("watchdog expired before %0d instructions had run", NUM_INSTR);
		$display("Result: FAILED");
		$finish;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit
	function automatic rv_pkg::word_t random_bits(int n);
		rv_pkg::word_t r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// immediate formats as the isa lays them out
	function automatic rv_pkg::word_t imm_i(rv_pkg::word_t ins);
		return {{20{ins[31]}}, ins[31:20]};
	endfunction

	function automatic rv_pkg::word_t imm_s(rv_pkg::word_t ins);
		return {{20{ins[31]}}, ins[31:25], ins[11:7]};
	endfunction

	function automatic rv_pkg::word_t imm_b(rv_pkg::word_t ins);
		return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
	endfunction

	function automatic rv_pkg::word_t imm_u(rv_pkg::word_t ins);
		return {ins[31:12], 12'b0};
	endfunction

	function automatic rv_pkg::word_t imm_j(rv_pkg::word_t ins);
		return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
	endfunction

	// register and immediate arithmetic in funct3 coding
	function automatic rv_pkg::word_t alu_ref(logic [2:0] f3, logic alt,
			rv_pkg::word_t a, rv_pkg::word_t b);
		rv_pkg::word_t r;
		case (f3)
			3'b000:
				r = alt ? (a - b) : (a + b);
			3'b001:
				r = a << b[4:0];
			3'b010:
				r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011:
				r = (a < b) ? 32'd1 : 32'd0;
			3'b100:
				r = a ^ b;
			3'b101:
				r = alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : (a >> b[4:0]);
			3'b110:
				r = a | b;
			default:
				r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_taken(logic [2:0] f3, rv_pkg::word_t a, rv_pkg::word_t b);
		logic t;
		case (f3)
			3'b000:
				t = (a == b);
			3'b001:
				t = (a != b);
			3'b100:
				t = ($signed(a) < $signed(b));
			3'b101:
				t = ($signed(a) >= $signed(b));
			3'b110:
				t = (a < b);
			default:
				t = (a >= b);
		endcase
		return t;
	endfunction

	// a word never stored reads as its address xor a pattern
	function automatic rv_pkg::word_t load_word(rv_pkg::word_t addr);
		if (dmem.exists(addr))
			return dmem[addr];
		return addr ^ 32'h5a5a5a5a;
	endfunction

	// multiple of 4 within +-256 and never zero so no branch to itself
	function automatic rv_pkg::word_t random_offset();
		rv_pkg::word_t r;
		r = random_bits(7);
		r = {{23{r[6]}}, r[6:0], 2'b00};
		if (r == '0)
			r = 32'd4;
		return r;
	endfunction

	function automatic rv_pkg::word_t make_instr();
		rv_pkg::word_t ins;
		rv_pkg::word_t imm;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic alt;
		logic [3:0] cls;
		rd = 5'(random_bits(5));
		rs1 = 5'(random_bits(5));
		rs2 = 5'(random_bits(5));
		f3 = 3'(random_bits(3));
		alt = 1'(random_bits(1));
		cls = 4'(random_bits(4));
		// first 31 fetches load x1 to x31 with lui or addi from x0
		if (fill_count < rv_pkg::NUM_REGS - 1)
		begin
			rd = 5'(fill_count + 1);
			imm = random_bits(20);
			if (alt)
				ins = {imm[19:0], rd, rv_pkg::OP_LUI};
			else
				ins = {imm[11:0], 5'd0, 3'b000, rd, rv_pkg::OP_ALU_IMM};
		end
		else if (cls < 4'd4)
		begin
			// bit 30 only for sub and sra
			ins = {1'b0, alt && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
				rs2, rs1, f3, rd, rv_pkg::OP_ALU_REG};
		end
		else if (cls < 4'd7)
		begin
			imm = random_bits(12);
			// shifts take a 5 bit amount and srai sets bit 30
			if (f3 == 3'b001 || f3 == 3'b101)
				imm = {20'b0, 1'b0, alt && (f3 == 3'b101), 5'b0, imm[4:0]};
			ins = {imm[11:0], rs1, f3, rd, rv_pkg::OP_ALU_IMM};
		end
		else if (cls == 4'd7 || cls == 4'd8)
		begin
			imm = random_bits(20);
			ins = {imm[19:0], rd, (cls == 4'd7) ? rv_pkg::OP_LUI : rv_pkg::OP_AUIPC};
		end
		else if (cls < 4'd11)
		begin
			// 010 and 011 are not branches so they fold onto the unsigned pair
			if (f3[2:1] == 2'b01)
				f3[2] = 1'b1;
			// equal operands a quarter of the time
			if (random_bits(2) == 0)
				rs2 = rs1;
			imm = random_offset();
			ins = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
		end
		else if (cls == 4'd11)
		begin
			imm = random_offset();
			ins = {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
		end
		else if (cls == 4'd12)
		begin
			imm = random_offset();
			ins = {imm[11:0], rs1, 3'b000, rd, rv_pkg::OP_JALR};
		end
		else
		begin
			imm = random_bits(12);
			// half of the accesses hit a small window off x0 so loads see stores
			if (random_bits(1) != 0)
			begin
				rs1 = '0;
				imm = random_bits(4) << 2;
			end
			if (cls == 4'd13)
				ins = {imm[11:0], rs1, 3'b010, rd, rv_pkg::OP_LOAD};
			else
				ins = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
		end
		return ins;
	endfunction

	function automatic rv_pkg::word_t fetch(rv_pkg::word_t addr);
		if (!imem.exists(addr))
		begin
			imem[addr] = make_instr();
			fill_count++;
		end
		return imem[addr];
	endfunction

	task automatic check_value(string name, rv_pkg::word_t expected, rv_pkg::word_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR t=%0t %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	// outputs of the current instruction sampled at the falling edge
	task automatic check_cycle();
		rv_pkg::word_t ins;
		logic store;
		logic load;
		ins = imem[m_pc];
		store = (ins[6:0] == rv_pkg::OP_STORE);
		load = (ins[6:0] == rv_pkg::OP_LOAD);
		check_value("imem_addr", m_pc, imem_addr);
		check_value("dmem_we", {31'b0, store}, {31'b0, dmem_we});
		if (store)
		begin
			check_value("dmem_addr", m_regs[ins[19:15]] + imm_s(ins), dmem_addr);
			check_value("dmem_wdata", m_regs[ins[24:20]], dmem_wdata);
		end
		// the load address has to match the word handed back on dmem_rdata
		if (load)
		begin
			check_value("dmem_addr", m_regs[ins[19:15]] + imm_i(ins), dmem_addr);
		end
	endtask

	// retire one instruction in the model
	task automatic model_step();
		rv_pkg::word_t ins;
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t rd_val;
		rv_pkg::word_t npc;
		logic we;
		ins = imem[m_pc];
		a = m_regs[ins[19:15]];
		b = m_regs[ins[24:20]];
		npc = m_pc + 32'd4;
		rd_val = '0;
		we = 1'b1;
		case (ins[6:0])
			rv_pkg::OP_LUI:
				rd_val = imm_u(ins);
			rv_pkg::OP_AUIPC:
				rd_val = m_pc + imm_u(ins);
			rv_pkg::OP_JAL:
			begin
				rd_val = m_pc + 32'd4;
				npc = m_pc + imm_j(ins);
			end
			rv_pkg::OP_JALR:
			begin
				rd_val = m_pc + 32'd4;
				npc = (a + imm_i(ins)) & ~32'd1;
			end
			rv_pkg::OP_BRANCH:
			begin
				we = 1'b0;
				if (branch_taken(ins[14:12], a, b))
					npc = m_pc + imm_b(ins);
			end
			rv_pkg::OP_LOAD:
				rd_val = load_word(a + imm_i(ins));
			rv_pkg::OP_STORE:
			begin
				we = 1'b0;
				dmem[a + imm_s(ins)] = b;
			end
			rv_pkg::OP_ALU_IMM:
				rd_val = alu_ref(ins[14:12], (ins[14:12] == 3'b101) && ins[30], a, imm_i(ins));
			rv_pkg::OP_ALU_REG:
				rd_val = alu_ref(ins[14:12], ins[30], a, b);
			default:
				we = 1'b0;
		endcase
		// x0 stays zero
		if (we && ins[11:7] != 5'd0)
			m_regs[ins[11:7]] = rd_val;
		m_pc = npc;
	endtask

	// next instruction and its load data go out with the edge
	task automatic drive_fetch();
		rv_pkg::word_t ins;
		ins = fetch(m_pc);
		imem_data <= ins;
		dmem_rdata <= load_word(m_regs[ins[19:15]] + imm_i(ins));
	endtask

	initial
	begin
		reset <= 1'b1;
		imem_data <= RESET_STORE;
		dmem_rdata <= '0;
		lfsr = 32'hfc3b;
		fill_count = 0;
		errors = 0;
		checks = 0;
		m_pc = '0;
		m_regs = '{default: '0};
		// the store on the fetch port must not reach the data port
		repeat (RESET_CYCLES - 1)
		begin
			@(posedge clk);
			@(negedge clk);
			check_value("dmem_we", '0, {31'b0, dmem_we});
		end
		@(posedge clk);
		reset <= 1'b0;
		drive_fetch();
		for (int n = 0; n < NUM_INSTR; n++)
		begin
			@(negedge clk);
			check_cycle();
			@(posedge clk);
			model_step();
			drive_fetch();
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
src/rv_pkg.sv
src/immediate_decode.sv
src/alu_decode.sv
src/instruction_decode.sv
src/register_file.sv
src/alu.sv
src/rv32i_core.sv
tb/tb_rv32i_core.sv

// ==== run.sh ====
#!/bin/sh
# build the rv32i core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary -f compile.f --top-module tb_rv32i_core -o tb_rv32i_core
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/tb_rv32i_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^Result: PASSED$'; then
	exit 0
fi
exit 1
